// ==== decode_pkg.sv ====
package decode_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------

    localparam int XLEN   = 32;    // Data path width
    localparam int REG_AW = 5;     // Register address width

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------

    // Major opcode field, low two bits included
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [1:0] {
        FU_NONE = 2'd0,            // Traps and bubbles
        FU_ALU  = 2'd1,
        FU_LSU  = 2'd2,
        FU_CFU  = 2'd3             // Branches and jumps
    } fu_e;

    typedef enum logic [4:0] {
        UOP_NONE = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_AND  = 5'd3,
        ALU_OR   = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_SLT  = 5'd6,
        ALU_SLTU = 5'd7,
        ALU_SLL  = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRA  = 5'd10,
        LSU_LB   = 5'd11,
        LSU_LH   = 5'd12,
        LSU_LW   = 5'd13,
        LSU_LBU  = 5'd14,
        LSU_LHU  = 5'd15,
        LSU_SB   = 5'd16,
        LSU_SH   = 5'd17,
        LSU_SW   = 5'd18,
        CFU_BEQ  = 5'd19,
        CFU_BNE  = 5'd20,
        CFU_BLT  = 5'd21,
        CFU_BGE  = 5'd22,
        CFU_BLTU = 5'd23,
        CFU_BGEU = 5'd24,
        CFU_JAL  = 5'd25,
        CFU_JALR = 5'd26
    } uop_e;

    // Trap causes, carried on rd
    localparam logic [4:0] TRAP_IACCESS = 5'd1;    // Fetch error
    localparam logic [4:0] TRAP_IOPCODE = 5'd2;    // Illegal encoding

    // One flag per operand source
    typedef struct packed {
        logic opa_rs1;             // A from rs1 data
        logic opa_pcim;            // A from pc + imm
        logic opb_rs2;             // B from rs2 data
        logic opb_imm;             // B from immediate
        logic opb_zero;            // B forced to zero
        logic opc_rs2;             // C from rs2 data
        logic opc_pcim;            // C from pc + imm
    } opr_sel_t;

endpackage

// ==== decode_stage_if.sv ====
`timescale 1ns/100ps

// Decoded record passed from the first stage to the operand stage.
// A transfer takes place on a clock edge with valid high and busy low.
interface decode_stage_if import decode_pkg::*; ();

    logic              valid;      // Record present
    logic              busy;       // Consumer cannot take it
    logic [XLEN-1:0]   pc;         // PC of the instruction
    uop_e              uop;
    fu_e               fu;
    logic [REG_AW-1:0] rd;         // Trap cause when trap is set
    logic [REG_AW-1:0] rs1;        // Zero when unused
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm;
    opr_sel_t          opr_sel;
    logic              trap;

    modport producer (
        output valid,
        output pc,
        output uop,
        output fu,
        output rd,
        output rs1,
        output rs2,
        output imm,
        output opr_sel,
        output trap,
        input  busy
    );

    modport consumer (
        input  valid,
        input  pc,
        input  uop,
        input  fu,
        input  rd,
        input  rs1,
        input  rs2,
        input  imm,
        input  opr_sel,
        input  trap,
        output busy
    );

endinterface

// ==== decode_top.sv ====
`timescale 1ns/100ps

module decode_top import decode_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET = 32'h8000_0000
) (
    input  logic                g_clk,
    input  logic                g_resetn,

    input  logic                i_valid,       // Fetch side
    output logic                o_busy,
    input  logic [XLEN-1:0]     i_instr,
    input  logic                i_fetch_err,

    output logic [REG_AW-1:0]   o_rs1_addr,    // Register file
    output logic [REG_AW-1:0]   o_rs2_addr,
    input  logic [XLEN-1:0]     i_rs1_rdata,
    input  logic [XLEN-1:0]     i_rs2_rdata,

    input  logic                i_cf_req,      // Redirect
    input  logic [XLEN-1:0]     i_cf_target,

    output logic                o_valid,       // Dispatch side
    input  logic                i_busy,
    output logic [REG_AW-1:0]   o_rd,
    output uop_e                o_uop,
    output fu_e                 o_fu,
    output logic                o_trap,
    output logic [XLEN-1:0]     o_opr_a,
    output logic [XLEN-1:0]     o_opr_b,
    output logic [XLEN-1:0]     o_opr_c
);

    decode_stage_if u_stage_if ();

    instr_decoder #(
        .PC_RESET (PC_RESET)
    ) u_instr_decoder (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_valid     (i_valid),
        .o_busy      (o_busy),
        .i_instr     (i_instr),
        .i_fetch_err (i_fetch_err),
        .i_cf_req    (i_cf_req),
        .i_cf_target (i_cf_target),
        .o_dec       (u_stage_if.producer)
    );

    operand_stage u_operand_stage (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_cf_req    (i_cf_req),
        .i_dec       (u_stage_if.consumer),
        .o_rs1_addr  (o_rs1_addr),
        .o_rs2_addr  (o_rs2_addr),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .o_valid     (o_valid),
        .i_busy      (i_busy),
        .o_rd        (o_rd),
        .o_uop       (o_uop),
        .o_fu        (o_fu),
        .o_trap      (o_trap),
        .o_opr_a     (o_opr_a),
        .o_opr_b     (o_opr_b),
        .o_opr_c     (o_opr_c)
    );

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen import decode_pkg::*; (
    input  logic [XLEN-1:0] i_instr,
    input  opcode_e         i_opcode,
    output logic [XLEN-1:0] o_imm
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_shamt;
    logic            shift_imm;

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};

    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};       // Halfword offset

    assign imm_u = {i_instr[31:12], 12'b0};

    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    assign imm_shamt = {{(XLEN-5){1'b0}}, i_instr[24:20]};      // Shift amount only

    // slli, srli and srai carry funct7 in the upper I bits
    assign shift_imm = (i_instr[13:12] == 2'b01);

    always_comb begin
        case (i_opcode)
            OP_IMM:       o_imm = shift_imm ? imm_shamt : imm_i;
            LOAD, JALR:   o_imm = imm_i;
            STORE:        o_imm = imm_s;
            BRANCH:       o_imm = imm_b;
            LUI, AUIPC:   o_imm = imm_u;
            JAL:          o_imm = imm_j;
            default:      o_imm = '0;                           // OP and illegal
        endcase
    end

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder import decode_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET = 32'h8000_0000
) (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                i_valid,
    output logic                o_busy,
    input  logic [XLEN-1:0]     i_instr,
    input  logic                i_fetch_err,
    input  logic                i_cf_req,
    input  logic [XLEN-1:0]     i_cf_target,
    decode_stage_if.producer    o_dec
);

    opcode_e           opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc;
    logic              illegal;
    logic              no_rd;
    logic              n_trap;
    uop_e              n_uop;
    fu_e               n_fu;
    opr_sel_t          n_sel;
    logic [REG_AW-1:0] n_rd;
    logic [REG_AW-1:0] n_rs1;
    logic [REG_AW-1:0] n_rs2;
    logic              accept;

    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    imm_gen u_imm_gen (
        .i_instr  (i_instr),
        .i_opcode (opcode),
        .o_imm    (imm)
    );

    // ALU op from funct3, alt selects sub / sra
    function automatic uop_e alu_uop(input logic [2:0] f3, input logic alt);
        uop_e u;
        case (f3)
            3'b000:  u = alt ? ALU_SUB : ALU_ADD;
            3'b001:  u = ALU_SLL;
            3'b010:  u = ALU_SLT;
            3'b011:  u = ALU_SLTU;
            3'b100:  u = ALU_XOR;
            3'b101:  u = alt ? ALU_SRA : ALU_SRL;
            3'b110:  u = ALU_OR;
            default: u = ALU_AND;
        endcase
        return u;
    endfunction

    // ------------------------------------------------------------------
    // Classification
    // ------------------------------------------------------------------

    always_comb begin
        illegal = 1'b0;
        no_rd   = 1'b0;
        n_uop   = UOP_NONE;
        n_fu    = FU_NONE;
        n_sel   = '0;
        case (opcode)
            OP: begin
                illegal = !(funct7 == 7'b0000000 ||
                            (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}));
                n_uop = alu_uop(funct3, funct7[5]);
                n_fu  = FU_ALU;
                n_sel.opa_rs1 = 1'b1;
                n_sel.opb_rs2 = 1'b1;
            end
            OP_IMM: begin
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000);                  // slli
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
                n_uop = alu_uop(funct3, funct3 == 3'b101 && funct7[5]);
                n_fu  = FU_ALU;
                n_sel.opa_rs1 = 1'b1;
                n_sel.opb_imm = 1'b1;
            end
            LUI: begin
                n_uop = ALU_OR;                                        // 0 | imm
                n_fu  = FU_ALU;
                n_sel.opb_imm = 1'b1;
            end
            AUIPC: begin
                n_uop = ALU_ADD;
                n_fu  = FU_ALU;
                n_sel.opa_pcim = 1'b1;
                n_sel.opb_zero = 1'b1;
            end
            LOAD: begin
                case (funct3)
                    3'b000:  n_uop = LSU_LB;
                    3'b001:  n_uop = LSU_LH;
                    3'b010:  n_uop = LSU_LW;
                    3'b100:  n_uop = LSU_LBU;
                    3'b101:  n_uop = LSU_LHU;
                    default: illegal = 1'b1;
                endcase
                n_fu = FU_LSU;
                n_sel.opa_rs1 = 1'b1;
                n_sel.opb_imm = 1'b1;
            end
            STORE: begin
                case (funct3)
                    3'b000:  n_uop = LSU_SB;
                    3'b001:  n_uop = LSU_SH;
                    3'b010:  n_uop = LSU_SW;
                    default: illegal = 1'b1;
                endcase
                n_fu  = FU_LSU;
                no_rd = 1'b1;
                n_sel.opa_rs1 = 1'b1;
                n_sel.opb_imm = 1'b1;
                n_sel.opc_rs2 = 1'b1;                                  // Store data
            end
            BRANCH: begin
                case (funct3)
                    3'b000:  n_uop = CFU_BEQ;
                    3'b001:  n_uop = CFU_BNE;
                    3'b100:  n_uop = CFU_BLT;
                    3'b101:  n_uop = CFU_BGE;
                    3'b110:  n_uop = CFU_BLTU;
                    3'b111:  n_uop = CFU_BGEU;
                    default: illegal = 1'b1;
                endcase
                n_fu  = FU_CFU;
                no_rd = 1'b1;
                n_sel.opa_rs1  = 1'b1;
                n_sel.opb_rs2  = 1'b1;
                n_sel.opc_pcim = 1'b1;                                 // Taken target
            end
            JAL: begin
                n_uop = CFU_JAL;
                n_fu  = FU_CFU;
                n_sel.opb_zero = 1'b1;
                n_sel.opc_pcim = 1'b1;
            end
            JALR: begin
                illegal = (funct3 != 3'b000);
                n_uop = CFU_JALR;
                n_fu  = FU_CFU;
                n_sel.opa_rs1 = 1'b1;
                n_sel.opb_imm = 1'b1;
            end
            default: illegal = 1'b1;
        endcase

        n_trap = i_fetch_err || illegal;
        if (n_trap) begin
            n_uop = UOP_NONE;
            n_fu  = FU_NONE;
            n_sel = '0;                                                // Nothing sourced
        end
    end

    // Fetch error wins over illegal encoding
    assign n_rd  = i_fetch_err ? TRAP_IACCESS :
                   illegal     ? TRAP_IOPCODE :
                   no_rd       ? '0           : i_instr[11:7];
    assign n_rs1 = n_sel.opa_rs1 ? i_instr[19:15] : '0;
    assign n_rs2 = (n_sel.opb_rs2 || n_sel.opc_rs2) ? i_instr[24:20] : '0;

    // ------------------------------------------------------------------
    // Handshake, PC and pipeline register
    // ------------------------------------------------------------------

    assign o_busy = (o_dec.valid && o_dec.busy) || i_cf_req;
    assign accept = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= PC_RESET;
        end else if (i_cf_req) begin
            pc <= i_cf_target;                                         // Redirect always taken
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_dec.valid <= 1'b0;
        end else if (i_cf_req) begin
            o_dec.valid <= 1'b0;                                       // Drop in-flight record
        end else if (accept) begin
            o_dec.valid <= 1'b1;
        end else if (!o_dec.busy) begin
            o_dec.valid <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_dec.pc      <= pc;
            o_dec.uop     <= n_uop;
            o_dec.fu      <= n_fu;
            o_dec.rd      <= n_rd;
            o_dec.rs1     <= n_rs1;
            o_dec.rs2     <= n_rs2;
            o_dec.imm     <= imm;
            o_dec.opr_sel <= n_sel;
            o_dec.trap    <= n_trap;
        end
    end

    a_trap_no_fu: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_dec.valid && o_dec.trap |-> o_dec.fu == FU_NONE);

endmodule

// ==== operand_stage.sv ====
`timescale 1ns/100ps

module operand_stage import decode_pkg::*; (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                i_cf_req,
    decode_stage_if.consumer    i_dec,
    output logic [REG_AW-1:0]   o_rs1_addr,
    output logic [REG_AW-1:0]   o_rs2_addr,
    input  logic [XLEN-1:0]     i_rs1_rdata,
    input  logic [XLEN-1:0]     i_rs2_rdata,
    output logic                o_valid,
    input  logic                i_busy,
    output logic [REG_AW-1:0]   o_rd,
    output uop_e                o_uop,
    output fu_e                 o_fu,
    output logic                o_trap,
    output logic [XLEN-1:0]     o_opr_a,
    output logic [XLEN-1:0]     o_opr_b,
    output logic [XLEN-1:0]     o_opr_c
);

    opr_sel_t        sel;
    logic            take;
    logic [XLEN-1:0] pc_imm;
    logic            opa_ld;
    logic            opb_ld;
    logic            opc_ld;
    logic [XLEN-1:0] n_opr_a;
    logic [XLEN-1:0] n_opr_b;
    logic [XLEN-1:0] n_opr_c;

    assign i_dec.busy = (o_valid && i_busy) || i_cf_req;
    assign take       = i_dec.valid && !i_dec.busy;
    assign sel        = i_dec.opr_sel;

    // Register file is read in the transfer cycle
    assign o_rs1_addr = i_dec.rs1;
    assign o_rs2_addr = i_dec.rs2;

    assign pc_imm = i_dec.pc + i_dec.imm;                              // auipc, branch, jal

    // ------------------------------------------------------------------
    // Operand muxes
    // ------------------------------------------------------------------

    // ALU ops always consume A, so lui loads zero here
    assign opa_ld = take && (sel.opa_rs1 || sel.opa_pcim || i_dec.fu == FU_ALU);
    assign opb_ld = take && (sel.opb_rs2 || sel.opb_imm || sel.opb_zero);
    assign opc_ld = take && (sel.opc_rs2 || sel.opc_pcim);

    assign n_opr_a = {XLEN{sel.opa_rs1 }} & i_rs1_rdata |
                     {XLEN{sel.opa_pcim}} & pc_imm;

    assign n_opr_b = {XLEN{sel.opb_rs2 }} & i_rs2_rdata |
                     {XLEN{sel.opb_imm }} & i_dec.imm;                 // Zero if opb_zero

    assign n_opr_c = {XLEN{sel.opc_rs2 }} & i_rs2_rdata |
                     {XLEN{sel.opc_pcim}} & pc_imm;

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_cf_req) begin
            o_valid <= 1'b0;
        end else if (take) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                                           // Taken downstream
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            o_rd   <= i_dec.rd;
            o_uop  <= i_dec.uop;
            o_fu   <= i_dec.fu;
            o_trap <= i_dec.trap;
        end
        if (opa_ld) begin
            o_opr_a <= n_opr_a;
        end
        if (opb_ld) begin
            o_opr_b <= n_opr_b;
        end
        if (opc_ld) begin
            o_opr_c <= n_opr_c;                                        // Else keep old value
        end
    end

    a_hold_outputs: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_valid && i_busy && !i_cf_req |=>
            $stable({o_valid, o_rd, o_uop, o_fu, o_trap, o_opr_a, o_opr_b, o_opr_c}));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the decode testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_decode_top -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// ==== tb.f ====
decode_pkg.sv
decode_stage_if.sv
imm_gen.sv
instr_decoder.sv
operand_stage.sv
decode_top.sv
tb_decode_top.sv

// ==== tb_decode_top.sv ====
`timescale 1ns/100ps

module tb_decode_top import decode_pkg::*; ();

    localparam int              CLK_PERIOD  = 40;
    localparam int              N_INSTR     = 2000;
    localparam int              WATCHDOG_NS = N_INSTR * 10 * CLK_PERIOD;
    localparam logic [XLEN-1:0] PC_RESET    = 32'h8000_0000;

    typedef struct packed {
        uop_e              uop;
        fu_e               fu;
        logic [REG_AW-1:0] rd;
        logic              trap;
        logic              chk_a;      // Operand sourced and compared
        logic              chk_b;
        logic              chk_c;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   c;
    } exp_t;

    logic g_clk;
    logic g_resetn;
    logic i_valid, o_busy, i_fetch_err, i_cf_req, o_valid, i_busy, o_trap;
    logic [XLEN-1:0]   i_instr, i_cf_target, i_rs1_rdata, i_rs2_rdata;
    logic [XLEN-1:0]   o_opr_a, o_opr_b, o_opr_c;
    logic [REG_AW-1:0] o_rs1_addr, o_rs2_addr, o_rd;
    uop_e              o_uop;
    fu_e               o_fu;

    logic [XLEN-1:0] regs [0:31];      // Register file model fixed after start
    exp_t            exp_q [$];
    logic [XLEN-1:0] model_pc;
    logic            acc_seen;         // Acceptance on the last rising edge
    logic            expect_out;       // o_valid due on this edge
    integer          seed = 10;
    int              mismatch_count = 0;
    int              fail_count = 0;

    assign i_rs1_rdata = regs[o_rs1_addr];
    assign i_rs2_rdata = regs[o_rs2_addr];

    decode_top #(.PC_RESET(PC_RESET)) decode_top_inst (.*);

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic check_uop(input string name, input uop_e got, input uop_e exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %s got %s (%0d)",
                     $time, name, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_fu(input string name, input fu_e got, input fu_e exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %s got %s (%0d)",
                     $time, name, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_AW-1:0] got,
                            input logic [REG_AW-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_trap(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_busy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function automatic uop_e alu_op_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic exp_t model_decode(input logic [XLEN-1:0] w, input logic ferr,
                                          input logic [XLEN-1:0] pc);
        exp_t            e;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] rs1v, rs2v, imm_i, imm_s, imm_b, imm_u, imm_j;
        logic            legal;
        f3    = w[14:12];
        f7    = w[31:25];
        rs1v  = regs[w[19:15]];
        rs2v  = regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        e     = '0;
        legal = 1'b1;
        e.rd  = w[11:7];
        e.fu  = FU_ALU;
        case (w[6:0])
            7'h33: begin                                   // Register ALU
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                e.uop = alu_op_of(f3, f7[5]);
                {e.chk_a, e.a, e.chk_b, e.b} = {1'b1, rs1v, 1'b1, rs2v};
            end
            7'h13: begin                                   // Immediate ALU
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                e.uop = alu_op_of(f3, f3 == 3'd5 && f7[5]);
                {e.chk_a, e.a, e.chk_b} = {1'b1, rs1v, 1'b1};
                e.b = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, w[24:20]} : imm_i;
            end
            7'h37: begin                                   // lui
                e.uop = ALU_OR;
                {e.chk_a, e.a, e.chk_b, e.b} = {1'b1, 32'b0, 1'b1, imm_u};
            end
            7'h17: begin                                   // auipc
                e.uop = ALU_ADD;
                {e.chk_a, e.a, e.chk_b, e.b} = {1'b1, pc + imm_u, 1'b1, 32'b0};
            end
            7'h03: begin                                   // Loads
                case (f3)
                    3'd0:    e.uop = LSU_LB;
                    3'd1:    e.uop = LSU_LH;
                    3'd2:    e.uop = LSU_LW;
                    3'd4:    e.uop = LSU_LBU;
                    3'd5:    e.uop = LSU_LHU;
                    default: legal = 1'b0;
                endcase
                e.fu = FU_LSU;
                {e.chk_a, e.a, e.chk_b, e.b} = {1'b1, rs1v, 1'b1, imm_i};
            end
            7'h23: begin                                   // Stores
                case (f3)
                    3'd0:    e.uop = LSU_SB;
                    3'd1:    e.uop = LSU_SH;
                    3'd2:    e.uop = LSU_SW;
                    default: legal = 1'b0;
                endcase
                e.fu = FU_LSU;
                e.rd = '0;
                {e.chk_a, e.a, e.chk_b, e.b} = {1'b1, rs1v, 1'b1, imm_s};
                {e.chk_c, e.c} = {1'b1, rs2v};
            end
            7'h63: begin                                   // Branches
                case (f3)
                    3'd0:    e.uop = CFU_BEQ;
                    3'd1:    e.uop = CFU_BNE;
                    3'd4:    e.uop = CFU_BLT;
                    3'd5:    e.uop = CFU_BGE;
                    3'd6:    e.uop = CFU_BLTU;
                    3'd7:    e.uop = CFU_BGEU;
                    default: legal = 1'b0;
                endcase
                e.fu = FU_CFU;
                e.rd = '0;
                {e.chk_a, e.a, e.chk_b, e.b} = {1'b1, rs1v, 1'b1, rs2v};
                {e.chk_c, e.c} = {1'b1, pc + imm_b};
            end
            7'h6f: begin                                   // jal
                e.uop = CFU_JAL;
                e.fu  = FU_CFU;
                {e.chk_b, e.b, e.chk_c, e.c} = {1'b1, 32'b0, 1'b1, pc + imm_j};
            end
            7'h67: begin                                   // jalr
                legal = (f3 == 3'd0);
                e.uop = CFU_JALR;
                e.fu  = FU_CFU;
                {e.chk_a, e.a, e.chk_b, e.b} = {1'b1, rs1v, 1'b1, imm_i};
            end
            default: legal = 1'b0;
        endcase
        if (ferr || !legal) begin
            e      = '0;
            e.trap = 1'b1;
            e.rd   = ferr ? TRAP_IACCESS : TRAP_IOPCODE;   // Fetch error first
        end
        return e;
    endfunction

    task automatic compare_output(input exp_t e);
        check_trap("o_trap", o_trap, e.trap);
        check_uop("o_uop", o_uop, e.uop);
        check_fu("o_fu", o_fu, e.fu);
        check_rd("o_rd", o_rd, e.rd);
        if (e.chk_a) check_word("o_opr_a", o_opr_a, e.a);
        if (e.chk_b) check_word("o_opr_b", o_opr_b, e.b);
        if (e.chk_c) check_word("o_opr_c", o_opr_c, e.c);
    endtask

    // Sampled on the rising edge before the DUT registers update
    always @(posedge g_clk) begin : monitor
        exp_t e;
        if (!g_resetn) begin
            exp_q.delete();
            model_pc   = PC_RESET;
            acc_seen   = 1'b0;
            expect_out = 1'b0;
        end else begin
            if (expect_out && !o_valid) begin
                fail_count++;
                $display("Error at %0t: o_valid did not rise 2 cycles after acceptance", $time);
            end
            expect_out = acc_seen && !i_busy && !i_cf_req;
            // Stage 1 stalls only with both stages full and the output held
            check_busy("o_busy", o_busy, i_cf_req || (i_busy && exp_q.size() == 2));
            if (o_valid && !i_busy) begin
                if (exp_q.size() == 0) begin
                    fail_count++;
                    $display("Error at %0t: output taken with no instruction in flight", $time);
                end else begin
                    e = exp_q.pop_front();
                    compare_output(e);
                end
            end
            acc_seen = i_valid && !o_busy;
            if (i_cf_req) begin
                exp_q.delete();                             // In-flight records dropped
                model_pc = i_cf_target;
            end else if (acc_seen) begin
                exp_q.push_back(model_decode(i_instr, i_fetch_err, model_pc));
                model_pc = model_pc + 32'd4;
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    task automatic make_instr(output logic [XLEN-1:0] w);
        int          kind;
        logic [31:0] r;
        w    = $random(seed);
        kind = {$random(seed)} % 11;
        r    = {$random(seed)};
        case (kind)
            0: begin
                w[6:0]   = 7'h33;
                w[31:25] = (w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = 7'h13;
                if (w[14:12] == 3'd1) begin
                    w[31:25] = 7'h00;
                end else if (w[14:12] == 3'd5) begin
                    w[31:25] = w[30] ? 7'h20 : 7'h00;
                end
            end
            2: w[6:0] = 7'h37;
            3: w[6:0] = 7'h17;
            4: w[6:0] = 7'h6f;
            5: begin
                r         = r % 5;
                w[6:0]    = 7'h03;
                w[14:12]  = (r[2:0] > 3'd2) ? r[2:0] + 3'd1 : r[2:0];   // 0,1,2,4,5
            end
            6: begin
                r        = r % 3;
                w[6:0]   = 7'h23;
                w[14:12] = r[2:0];
            end
            7: begin
                r        = r % 6;
                w[6:0]   = 7'h63;
                w[14:12] = (r[2:0] > 3'd1) ? r[2:0] + 3'd2 : r[2:0];    // Skips 2 and 3
            end
            8: begin
                w[6:0]   = 7'h67;
                w[14:12] = 3'd0;
            end
            default: begin
                if (w[0]) begin
                    w[6:0]   = 7'h03;                       // Load with a reserved funct3
                    w[14:12] = 3'b011;
                end
            end
        endcase
    endtask

    task automatic drive_stimulus();
        int              n_sent;
        logic [XLEN-1:0] w;
        n_sent = 0;
        while (n_sent < N_INSTR) begin
            @(negedge g_clk);
            if (acc_seen) n_sent++;
            if (n_sent < N_INSTR) begin
                if (acc_seen || !i_valid) begin
                    make_instr(w);
                    i_instr     = w;
                    i_fetch_err = ({$random(seed)} % 16) == 0;
                    i_valid     = ({$random(seed)} % 4) != 0;
                end
                i_busy      = ({$random(seed)} % 3) == 0;
                i_cf_req    = ({$random(seed)} % 64) == 0;
                i_cf_target = {$random(seed)} & 32'hFFFF_FFFC;
            end
        end
        i_valid  = 1'b0;
        i_busy   = 1'b0;
        i_cf_req = 1'b0;
    endtask

    initial begin : main
        g_resetn    = 1'b0;
        i_valid     = 1'b0;
        i_instr     = '0;
        i_fetch_err = 1'b0;
        i_cf_req    = 1'b0;
        i_cf_target = '0;
        i_busy      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = $random(seed);
        end
        regs[0] = '0;                                       // x0 reads zero
        repeat (5) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        if (o_valid || o_busy) begin
            fail_count++;
            $display("Error at %0t: o_valid or o_busy high after reset", $time);
        end
        drive_stimulus();
        while (exp_q.size() != 0) @(posedge g_clk);
        repeat (4) @(posedge g_clk);                        // Catch late extra outputs
        $display("Mismatches: %0d, other errors: %0d", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d cycles", N_INSTR * 10);
        $display("Regression failed");
        $finish;
    end

endmodule
